//--- include/pxct_params.svh
// Width definitions shared by the previous-context unit
`ifndef PXCT_PARAMS_SVH
`define PXCT_PARAMS_SVH

// Data path word
// Data path ports use PDP-10 bit order, bit 0 is the MSB
`define DATA_WIDTH 36

// Microcode memory reference address
`define ADDR_WIDTH 18

// AC block number, eight blocks of sixteen ACs
`define BLOCK_WIDTH 3

// APB address
// Bit 19 selects the fast-memory window
// Bit 18 marks a previous-context section
`define PADDR_WIDTH 20

// Accumulator references fall below this address
`define AC_LIMIT 16

`endif

//--- logic/pxctPkg.sv
// Shared types of the previous-context unit: microcode control, requests and APB
`include "pxct_params.svh"

package pxctPkg;

   ////////////////////////////////////////////////////////////
   // Microcode side
   ////////////////////////////////////////////////////////////

   // Special function strobes
   // pxctEn and pxctOff may come together or alone
   typedef struct packed {
      logic loadAcBlk;
      logic pxctEn;
      logic pxctOff;
   } ucodeCtl;

   // Context selector carried by every memory reference
   typedef enum logic [2:0] {
      current  = 3'd0,   // Never previous
      e1Ea     = 3'd1,   // E1, PXCT EA
      e1D1     = 3'd2,
      d1Data   = 3'd3,   // D1, data or BLT destination
      bisSrcEa = 3'd4,
      e2Ptr    = 3'd5,   // E2, byte pointer EA
      bisDstEa = 3'd6,
      d2Data   = 3'd7    // D2, byte data or BLT source
   } pxctSelE;

   // Memory reference from the microcode
   typedef struct packed {
      logic [`ADDR_WIDTH-1:0] addr;
      logic                   write;
      logic [`DATA_WIDTH-1:0] wdata;
      pxctSelE                pxctSel;
   } memReq;

   // Current and previous AC block
   typedef struct packed {
      logic [`BLOCK_WIDTH-1:0] curBlock;
      logic [`BLOCK_WIDTH-1:0] prevBlock;
   } blockPair;

   // One APB reference, address already mapped
   typedef struct packed {
      logic [`PADDR_WIDTH-1:0] paddr;
      logic                    pwrite;
      logic [`DATA_WIDTH-1:0]  pwdata;
   } apbReq;

endpackage

//--- logic/contextBlocks.sv
// AC block register holding the current and previous accumulator block
`include "pxct_params.svh"

module contextBlocks
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  pxctPkg::ucodeCtl       ctl,
   // PDP-10 bit order
   input  logic [0:`DATA_WIDTH-1] dp,
   output pxctPkg::blockPair      blocks
);

   // Load strobe, qualified by the clock enable
   logic load;

   assign load = clken && ctl.loadAcBlk;

   ////////////////////////////////////////////////////////////
   // Block register
   ////////////////////////////////////////////////////////////

   // Current block from dp 6..8, previous block from dp 9..11
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         blocks <= '0;
      end
      else if (load)
      begin
         blocks.curBlock  <= dp[6:8];
         blocks.prevBlock <= dp[9:11];
      end
   end

   // Loaded block bits must be known on the load edge
   loadKnown : assert property (@(posedge clk) disable iff (rst)
      load |-> !$isunknown(dp[6:11]));

endmodule

//--- logic/pxctDecode.sv
// PXCT register and decode of the reference context selector into previous-enable
`include "pxct_params.svh"

module pxctDecode
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  pxctPkg::ucodeCtl       ctl,
   // PDP-10 bit order
   input  logic [0:`DATA_WIDTH-1] dp,
   input  pxctPkg::pxctSelE       pxctSel,
   output logic                   prevEn
);

   // PXCT enable
   logic       pxctOn;
   // E1, D1, E2 and D2 numbered as in the XCT AC field
   logic [9:12] pxctBits;

   ////////////////////////////////////////////////////////////
   // PXCT register
   ////////////////////////////////////////////////////////////

   // pxctOff only acts together with pxctEn
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pxctOn   <= 1'b0;
         pxctBits <= '0;
      end
      else if (clken && ctl.pxctEn)
      begin
         pxctOn   <= !ctl.pxctOff;
         pxctBits <= dp[9:12];
      end
   end

   ////////////////////////////////////////////////////////////
   // Selector decode
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      prevEn = 1'b0;
      if (pxctOn)
      begin
         case (pxctSel)
            pxctPkg::current  : prevEn = 1'b0;
            pxctPkg::e1Ea     : prevEn = pxctBits[9];
            pxctPkg::e1D1     : prevEn = pxctBits[10] && pxctBits[9];
            pxctPkg::d1Data   : prevEn = pxctBits[10];
            // Two-operand strings also need E1
            pxctPkg::bisSrcEa : prevEn = pxctBits[11] && pxctBits[9];
            pxctPkg::e2Ptr    : prevEn = pxctBits[11];
            pxctPkg::bisDstEa : prevEn = pxctBits[12] && pxctBits[9];
            pxctPkg::d2Data   : prevEn = pxctBits[12];
            default           : prevEn = 1'b0;
         endcase
      end
   end

   // Context bits and off strobe must be known on the load edge
   pxctLoadKnown : assert property (@(posedge clk) disable iff (rst)
      (clken && ctl.pxctEn) |-> !$isunknown({ctl.pxctOff, dp[9:12]}));

endmodule

//--- logic/contextAddress.sv
// Maps a memory reference to a physical address and holds it for the APB master
`include "pxct_params.svh"

module contextAddress
(
   input  logic              clk,
   input  logic              rst,
   // Microcode request
   input  logic              reqValid,
   input  pxctPkg::memReq    req,
   output logic              reqReady,
   // Context from the two registers
   input  pxctPkg::blockPair blocks,
   input  logic              prevEn,
   // Holding stage toward the master
   output logic              holdValid,
   output pxctPkg::apbReq    held,
   input  logic              holdTaken
);

   logic                    accept;
   logic [`BLOCK_WIDTH-1:0] block;
   pxctPkg::apbReq          nextHeld;

   // One-entry stage, ready only while empty
   assign reqReady = !holdValid;
   assign accept   = reqValid && reqReady;

   // Previous block when the reference runs in previous context
   assign block = prevEn ? blocks.prevBlock : blocks.curBlock;

   ////////////////////////////////////////////////////////////
   // Address mapping
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      nextHeld = '0;
      if (req.addr < `ADDR_WIDTH'(`AC_LIMIT))
      begin
         // Fast-memory window, block then AC number
         nextHeld.paddr[`PADDR_WIDTH-1]     = 1'b1;
         nextHeld.paddr[4 +: `BLOCK_WIDTH]  = block;
         nextHeld.paddr[3:0]                = req.addr[3:0];
      end
      else
      begin
         // Main memory, section bit 18 from context
         nextHeld.paddr[`PADDR_WIDTH-2]     = prevEn;
         nextHeld.paddr[`ADDR_WIDTH-1:0]    = req.addr;
      end
      nextHeld.pwrite = req.write;
      nextHeld.pwdata = req.wdata;
   end

   ////////////////////////////////////////////////////////////
   // Holding stage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         holdValid <= 1'b0;
      else if (accept)
         holdValid <= 1'b1;
      else if (holdTaken)
         holdValid <= 1'b0;
   end

   // Payload only
   always_ff @(posedge clk)
   begin
      if (accept)
         held <= nextHeld;
   end

   // Master must not take an empty stage
   takeOnlyHeld : assert property (@(posedge clk) disable iff (rst)
      holdTaken |-> holdValid);

endmodule

//--- logic/apbRefMaster.sv
// APB master running one transfer per held reference and returning the response
`include "pxct_params.svh"

module apbRefMaster
(
   input  logic                    clk,
   input  logic                    rst,
   // Holding stage
   input  logic                    holdValid,
   input  pxctPkg::apbReq          held,
   output logic                    holdTaken,
   // APB
   output logic                    psel,
   output logic                    penable,
   output logic [`PADDR_WIDTH-1:0] paddr,
   output logic                    pwrite,
   output logic [`DATA_WIDTH-1:0]  pwdata,
   input  logic [`DATA_WIDTH-1:0]  prdata,
   input  logic                    pready,
   // Response
   output logic                    respValid,
   output logic [`DATA_WIDTH-1:0]  respData
);

   typedef enum logic [1:0] {
      stIdle,
      stSetup,
      stAccess
   } stateE;

   stateE          state;
   pxctPkg::apbReq xfer;
   logic           done;
   logic           start;

   // Access phase ends on pready
   assign done  = (state == stAccess) && pready;
   // New setup from idle or straight after a finished access
   assign start = holdValid && ((state == stIdle) || done);

   ////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= stIdle;
      else if (start)
         state <= stSetup;
      else if (state == stSetup)
         state <= stAccess;
      else if (done)
         state <= stIdle;
   end

   // Own copy since the stage may refill during access
   always_ff @(posedge clk)
   begin
      if (start)
         xfer <= held;
   end

   // Stage is released in the setup cycle
   assign holdTaken = (state == stSetup);

   assign psel    = (state != stIdle);
   assign penable = (state == stAccess);
   assign paddr   = xfer.paddr;
   assign pwrite  = xfer.pwrite;
   assign pwdata  = xfer.pwdata;

   ////////////////////////////////////////////////////////////
   // Response
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         respValid <= 1'b0;
      else
         respValid <= done;
   end

   // Writes answer zero
   always_ff @(posedge clk)
   begin
      if (done)
         respData <= xfer.pwrite ? '0 : prdata;
   end

   // Held payload stays put until the master takes it
   heldStable : assert property (@(posedge clk) disable iff (rst)
      (holdValid && !holdTaken) |=> $stable(held));

   // Read data known when a read completes
   readKnown : assert property (@(posedge clk) disable iff (rst)
      (done && !xfer.pwrite) |-> !$isunknown(prdata));

endmodule

//--- logic/pxctUnit.sv
// Previous-context unit top: context registers, address mapping and APB master
`include "pxct_params.svh"

module pxctUnit
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clken,
   // Microcode control and data path
   input  pxctPkg::ucodeCtl        ctl,
   input  logic [0:`DATA_WIDTH-1]  dp,
   // Memory reference handshake
   input  logic                    reqValid,
   output logic                    reqReady,
   input  pxctPkg::memReq          req,
   // Response
   output logic                    respValid,
   output logic [`DATA_WIDTH-1:0]  respData,
   // APB
   output logic                    psel,
   output logic                    penable,
   output logic [`PADDR_WIDTH-1:0] paddr,
   output logic                    pwrite,
   output logic [`DATA_WIDTH-1:0]  pwdata,
   input  logic [`DATA_WIDTH-1:0]  prdata,
   input  logic                    pready
);

   pxctPkg::blockPair blocks;
   logic              prevEn;
   logic              holdValid;
   logic              holdTaken;
   pxctPkg::apbReq    held;

   // Context registers side by side
   contextBlocks blocks0 (.clk, .rst, .clken, .ctl, .dp, .blocks);

   pxctDecode decode0 (.clk, .rst, .clken, .ctl, .dp, .pxctSel(req.pxctSel), .prevEn);

   // Mapping and holding stage
   contextAddress addr0 (.clk, .rst, .reqValid, .req, .reqReady, .blocks, .prevEn,
                         .holdValid, .held, .holdTaken);

   // APB side
   apbRefMaster master0 (.clk, .rst, .holdValid, .held, .holdTaken, .psel, .penable,
                         .paddr, .pwrite, .pwdata, .prdata, .pready, .respValid,
                         .respData);

endmodule

//--- dv/apbMemSlave.sv
// APB memory model with random wait states and a paddr-derived read pattern
`include "pxct_params.svh"

module apbMemSlave
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    psel,
   input  logic                    penable,
   input  logic [`PADDR_WIDTH-1:0] paddr,
   input  logic                    pwrite,
   input  logic [`DATA_WIDTH-1:0]  pwdata,
   output logic [`DATA_WIDTH-1:0]  prdata,
   output logic                    pready
);
   timeunit 1ns;
   timeprecision 1ps;

   // Untouched words read back as paddr XOR this pattern
   localparam logic [`DATA_WIDTH-1:0] PAT = 36'h5a5a5a5a5;

   // Written words by address
   logic [`DATA_WIDTH-1:0] mem [logic [`PADDR_WIDTH-1:0]];
   int                     seed = 32'h7c65_083e;
   int unsigned            waits;

   // Ready once the drawn wait states have run out
   assign pready = penable && (waits == 0);

   always @(posedge clk)
   begin
      if (rst)
         waits <= 0;
      else if (psel && !penable)
      begin
         // Setup cycle draws 0 to 3 wait states and looks up the word
         waits  <= $unsigned($random(seed)) % 4;
         prdata <= mem.exists(paddr) ? mem[paddr] : ({16'b0, paddr} ^ PAT);
      end
      else if (penable && waits != 0)
         waits <= waits - 1;
      // Write lands on the completing edge
      if (psel && penable && pready && pwrite)
         mem[paddr] = pwdata;
   end

endmodule

//--- dv/pxctUnitTb.sv
// Table-driven testbench for the previous-context unit on an APB memory model
`include "pxct_params.svh"

module pxctUnitTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 40;
   localparam int NSTEPS     = 32;
   // Read pattern of untouched memory
   localparam logic [`DATA_WIDTH-1:0] PAT = 36'h5a5a5a5a5;

   // Each step holds strobes, dp bits 6 to 12, an optional reference and expected results
   typedef struct packed {
      logic [63:0]              name;
      logic [3:0]               enCtl;    // clken, loadAcBlk, pxctEn, pxctOff
      logic [6:0]               dpF;
      logic [2:0]               flags;    // request, no wait, write
      logic [`ADDR_WIDTH-1:0]   addr;
      logic [`DATA_WIDTH-1:0]   wdata;
      logic [2:0]               sel;
      logic [`PADDR_WIDTH-1:0]  expPaddr;
      logic [`DATA_WIDTH-1:0]   expData;
   } stepT;

   localparam stepT STEPS [NSTEPS] = '{
      '{"rstAc   ", 4'b1000, 7'h00, 3'b100, 18'h00005, 36'h0, 3'd7, 20'h80005, PAT ^ 36'h80005},
      '{"rstMem  ", 4'b1000, 7'h00, 3'b100, 18'h01234, 36'h0, 3'd1, 20'h01234, PAT ^ 36'h01234},
      '{"ldBlk   ", 4'b1100, 7'b011_101_0, 3'b000, 18'h0, 36'h0, 3'd0, 20'h0, 36'h0},
      '{"curAc   ", 4'b1000, 7'h00, 3'b100, 18'h00007, 36'h0, 3'd0, 20'h80037, PAT ^ 36'h80037},
      '{"pxOn1   ", 4'b1010, 7'b000_1010, 3'b000, 18'h0, 36'h0, 3'd0, 20'h0, 36'h0},
      '{"selCur  ", 4'b1000, 7'h00, 3'b100, 18'h3ffff, 36'h0, 3'd0, 20'h3ffff, PAT ^ 36'h3ffff},
      '{"selE1   ", 4'b1000, 7'h00, 3'b100, 18'h00003, 36'h0, 3'd1, 20'h80053, PAT ^ 36'h80053},
      '{"selE1D1 ", 4'b1000, 7'h00, 3'b100, 18'h00100, 36'h0, 3'd2, 20'h00100, PAT ^ 36'h00100},
      '{"selD1   ", 4'b1000, 7'h00, 3'b100, 18'h00003, 36'h0, 3'd3, 20'h80033, PAT ^ 36'h80033},
      '{"selBSrc ", 4'b1000, 7'h00, 3'b100, 18'h00100, 36'h0, 3'd4, 20'h40100, PAT ^ 36'h40100},
      '{"selE2   ", 4'b1000, 7'h00, 3'b100, 18'h00002, 36'h0, 3'd5, 20'h80052, PAT ^ 36'h80052},
      '{"selBDst ", 4'b1000, 7'h00, 3'b100, 18'h02000, 36'h0, 3'd6, 20'h02000, PAT ^ 36'h02000},
      '{"selD2   ", 4'b1000, 7'h00, 3'b100, 18'h02000, 36'h0, 3'd7, 20'h02000, PAT ^ 36'h02000},
      '{"pxOn2   ", 4'b1010, 7'b000_0111, 3'b000, 18'h0, 36'h0, 3'd0, 20'h0, 36'h0},
      '{"sel3b   ", 4'b1000, 7'h00, 3'b100, 18'h00400, 36'h0, 3'd3, 20'h40400, PAT ^ 36'h40400},
      '{"sel7b   ", 4'b1000, 7'h00, 3'b100, 18'h0000f, 36'h0, 3'd7, 20'h8005f, PAT ^ 36'h8005f},
      '{"sel4b   ", 4'b1000, 7'h00, 3'b100, 18'h00100, 36'h0, 3'd4, 20'h00100, PAT ^ 36'h00100},
      '{"sel6b   ", 4'b1000, 7'h00, 3'b100, 18'h00009, 36'h0, 3'd6, 20'h80039, PAT ^ 36'h80039},
      '{"pxOn3   ", 4'b1010, 7'b000_1111, 3'b000, 18'h0, 36'h0, 3'd0, 20'h0, 36'h0},
      '{"sel2c   ", 4'b1000, 7'h00, 3'b100, 18'h00400, 36'h0, 3'd2, 20'h40400, PAT ^ 36'h40400},
      '{"pxOff   ", 4'b1011, 7'b000_1111, 3'b000, 18'h0, 36'h0, 3'd0, 20'h0, 36'h0},
      '{"offSel7 ", 4'b1000, 7'h00, 3'b100, 18'h00001, 36'h0, 3'd7, 20'h80031, PAT ^ 36'h80031},
      '{"noClk   ", 4'b0110, 7'b111_1111, 3'b000, 18'h0, 36'h0, 3'd0, 20'h0, 36'h0},
      '{"noClkChk", 4'b1000, 7'h00, 3'b100, 18'h00002, 36'h0, 3'd7, 20'h80032, PAT ^ 36'h80032},
      '{"wr1     ", 4'b1000, 7'h00, 3'b101, 18'h00500, 36'h123456789, 3'd0, 20'h00500, 36'h0},
      '{"rd1     ", 4'b1000, 7'h00, 3'b100, 18'h00500, 36'h0, 3'd0, 20'h00500, 36'h123456789},
      '{"wrAc    ", 4'b1000, 7'h00, 3'b101, 18'h00004, 36'hfedcba987, 3'd0, 20'h80034, 36'h0},
      '{"rdAc    ", 4'b1000, 7'h00, 3'b100, 18'h00004, 36'h0, 3'd0, 20'h80034, 36'hfedcba987},
      '{"bbWr    ", 4'b1000, 7'h00, 3'b111, 18'h00600, 36'h0abcdef01, 3'd0, 20'h00600, 36'h0},
      '{"bbRd    ", 4'b1000, 7'h00, 3'b110, 18'h00600, 36'h0, 3'd0, 20'h00600, 36'h0abcdef01},
      '{"bbRd2   ", 4'b1000, 7'h00, 3'b110, 18'h00700, 36'h0, 3'd0, 20'h00700, PAT ^ 36'h00700},
      '{"bbRd3   ", 4'b1000, 7'h00, 3'b100, 18'h00008, 36'h0, 3'd0, 20'h80038, PAT ^ 36'h80038}
   };

   logic                    clk;
   logic                    rst;
   logic                    clken;
   pxctPkg::ucodeCtl        ctl;
   logic [0:`DATA_WIDTH-1]  dp;
   logic                    reqValid;
   logic                    reqReady;
   pxctPkg::memReq          req;
   logic                    respValid;
   logic [`DATA_WIDTH-1:0]  respData;
   logic                    psel;
   logic                    penable;
   logic [`PADDR_WIDTH-1:0] paddr;
   logic                    pwrite;
   logic [`DATA_WIDTH-1:0]  pwdata;
   logic [`DATA_WIDTH-1:0]  prdata;
   logic                    pready;
   stepT                    s;
   int                      idx;
   int                      errors = 0;
   int                      checks = 0;
   // Step indices awaiting their APB setup and their response
   int                      addrQ [$];
   int                      respQ [$];

   always #(CLK_PERIOD / 2) clk = !clk;

   pxctUnit dut0 (.*);

   apbMemSlave mem0 (.*);

   // Places bits 6 to 12 into a PDP-10 ordered word
   function automatic logic [0:`DATA_WIDTH-1] placeDp(input logic [6:0] f);
      logic [0:`DATA_WIDTH-1] w;
      w       = '0;
      w[6:12] = f;
      return w;
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk      = 1'b0;
      rst      = 1'b1;
      clken    = 1'b1;
      ctl      = '0;
      dp       = '0;
      reqValid = 1'b0;
      req      = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < NSTEPS; i++)
      begin
         s = STEPS[i];
         @(posedge clk);
         clken    <= s.enCtl[3];
         ctl      <= s.enCtl[2:0];
         dp       <= placeDp(s.dpF);
         reqValid <= s.flags[2];
         req      <= '{s.addr, s.flags[0], s.wdata, pxctPkg::pxctSelE'(s.sel)};
         if (s.flags[2])
         begin
            addrQ.push_back(i);
            respQ.push_back(i);
            // Taken on the edge after reqReady is seen high
            @(negedge clk);
            while (!reqReady)
               @(negedge clk);
            if (!s.flags[1])
            begin
               @(posedge clk);
               reqValid <= 1'b0;
               while (respQ.size() != 0)
                  @(negedge clk);
            end
         end
      end
      @(posedge clk);
      reqValid <= 1'b0;
      ctl      <= '0;
      while (respQ.size() != 0)
         @(negedge clk);
      repeat (4) @(posedge clk);
      checks++;
      assert (addrQ.size() == 0)
      else
      begin
         $display("A request was answered without its own APB transfer");
         errors++;
      end
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Monitors
   ////////////////////////////////////////////////////////////

   // Checks the address at each setup cycle and the data at each response
   always @(negedge clk)
   begin
      if (!rst && psel && !penable)
      begin
         if (addrQ.size() == 0)
         begin
            $display("An APB transfer started with no request outstanding");
            errors++;
         end
         else
         begin
            idx = addrQ.pop_front();
            checks++;
            assert (paddr == STEPS[idx].expPaddr)
            else
            begin
               $display("ERR %s paddr expected %h actual %h", STEPS[idx].name,
                        STEPS[idx].expPaddr, paddr);
               errors++;
            end
         end
      end
      if (!rst && respValid)
      begin
         if (respQ.size() == 0)
         begin
            $display("A response came with no request outstanding");
            errors++;
         end
         else
         begin
            idx = respQ.pop_front();
            checks++;
            assert (respData == STEPS[idx].expData)
            else
            begin
               $display("ERR %s respData expected %h actual %h", STEPS[idx].name,
                        STEPS[idx].expData, respData);
               errors++;
            end
         end
      end
   end

   // Watchdog allows twenty cycles per step
   initial
   begin
      #(NSTEPS * 20 * CLK_PERIOD);
      $display("Timeout, the DUT stopped responding before the table finished");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- pxctUnit.f
+incdir+include
logic/pxctPkg.sv
logic/contextBlocks.sv
logic/pxctDecode.sv
logic/contextAddress.sv
logic/apbRefMaster.sv
logic/pxctUnit.sv
dv/apbMemSlave.sv
dv/pxctUnitTb.sv

//--- Makefile
# Verilator simulation of the previous-context unit

TOP = pxctUnitTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f pxctUnit.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "Test failed"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || { echo "Test did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log
